//--- vlog.f
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
decode/registerFile.sv
decode/decodeStage.sv
source/fetchUnit.sv
source/executeStage.sv
source/memoryStage.sv
source/mipsCore.sv
verification/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - common
    files:
      - common/isaPkg.sv
      - common/pipePkg.sv
      - decode/registerFile.sv
      - decode/decodeStage.sv
      - source/fetchUnit.sv
      - source/executeStage.sv
      - source/memoryStage.sv
      - source/mipsCore.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/mipsCoreTb.sv

//--- verification/mipsCoreTb.sv
// self-checking testbench; each program ends in a self-jump and is loaded while reset is high
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module mipsCoreTb;

	logic Reset;
	logic clk;
	logic imemWrite;
	pipePkg::imemIdxT imemAddr;
	isaPkg::instrT imemData;
	logic wbValid;
	isaPkg::regIdxT wbReg;
	isaPkg::wordT wbData;
	logic storeValid;
	pipePkg::dmemIdxT storeAddr;
	isaPkg::wordT storeData;

	isaPkg::instrT prog [`CPU_IMEM_DEPTH];
	int progLen;
	logic [31:0] rngState = 32'h5c06;
	isaPkg::functT fnTable [5] = '{`CPU_FN_ADD, `CPU_FN_SUB, `CPU_FN_AND, `CPU_FN_OR, `CPU_FN_SLT};

	// expected events in retirement order
	isaPkg::regIdxT expRegIdx[$];
	isaPkg::wordT expRegData[$];
	pipePkg::dmemIdxT expStoreIdx[$];
	isaPkg::wordT expStoreData[$];

	int testErrors;
	int passCount;
	int failCount;

	mipsCore u_mipsCore (.*);

	always #5 Reset = ~Reset;

	// ------------------------------------------------------------
	// program builder
	// ------------------------------------------------------------
	function automatic isaPkg::instrT encR(isaPkg::functT fn, isaPkg::regIdxT rd,
			isaPkg::regIdxT rs, isaPkg::regIdxT rt);
		return {`CPU_OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic isaPkg::instrT encI(isaPkg::opcodeT op, isaPkg::regIdxT rt,
			isaPkg::regIdxT rs, isaPkg::immT imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic isaPkg::instrT encJ(isaPkg::jumpIdxT idx);
		return {`CPU_OP_J, idx};
	endfunction

	function automatic void clearProgram();
		progLen = 0;
		for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
			prog[i] = encJ(isaPkg::jumpIdxT'(i)); // every spare word jumps to itself
		end
	endfunction

	function automatic void emit(isaPkg::instrT ins);
		prog[progLen] = ins;
		progLen++;
	endfunction

	function automatic void endProgram();
		emit(encJ(isaPkg::jumpIdxT'(progLen)));
	endfunction

	function automatic logic [31:0] xorshift();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	// ------------------------------------------------------------
	// reference model that runs the program up to its self-jump
	// ------------------------------------------------------------
	function automatic void runModel();
		isaPkg::wordT regs [`CPU_NREGS];
		isaPkg::wordT dmem [`CPU_DMEM_DEPTH];
		isaPkg::wordT pc;
		isaPkg::wordT nextPc;
		isaPkg::instrT ins;
		isaPkg::wordT a;
		isaPkg::wordT b;
		isaPkg::wordT res;
		isaPkg::immT imm;
		bit halted;
		expRegIdx.delete();
		expRegData.delete();
		expStoreIdx.delete();
		expStoreData.delete();
		for (int i = 0; i < `CPU_NREGS; i++) begin
			regs[i] = (i == 0) ? '0 : `CPU_REG_RESET;
		end
		for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
			dmem[i] = `CPU_DMEM_RESET;
		end
		pc = '0;
		halted = 1'b0;
		for (int step = 0; step < 1000 && !halted; step++) begin
			ins = prog[pc[7:2]];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm = ins[15:0];
			nextPc = pc + 32'd4;
			res = a + {16'b0, imm}; // addi, lw and sw sum
			case (ins[31:26])
				`CPU_OP_RTYPE: begin
					case (ins[5:0])
						`CPU_FN_ADD: res = a + b;
						`CPU_FN_SUB: res = a - b;
						`CPU_FN_AND: res = a & b;
						`CPU_FN_OR:  res = a | b;
						`CPU_FN_SLT: res = (a < b) ? 32'd1 : 32'd0; // unsigned
						default:     res = '0;
					endcase
					expRegIdx.push_back(ins[15:11]);
					expRegData.push_back(res);
					if (ins[15:11] != 5'd0)
						regs[ins[15:11]] = res;
				end
				`CPU_OP_ADDI, `CPU_OP_LW: begin
					if (ins[31:26] == `CPU_OP_LW)
						res = dmem[res[7:0]];
					expRegIdx.push_back(ins[20:16]);
					expRegData.push_back(res);
					if (ins[20:16] != 5'd0)
						regs[ins[20:16]] = res;
				end
				`CPU_OP_SW: begin
					dmem[res[7:0]] = b;
					expStoreIdx.push_back(res[7:0]);
					expStoreData.push_back(b);
				end
				`CPU_OP_BEQ: begin
					if (a == b)
						nextPc = nextPc + {14'b0, imm, 2'b0};
				end
				`CPU_OP_J: begin
					nextPc = {4'b0, ins[25:0], 2'b0};
					halted = (nextPc == pc);
				end
				default: ;
			endcase
			pc = nextPc;
		end
	endfunction

	// ------------------------------------------------------------
	// checkers and monitor
	// ------------------------------------------------------------
	task automatic checkReg(input isaPkg::regIdxT gotReg, input isaPkg::wordT gotData);
		isaPkg::regIdxT expIdx;
		isaPkg::wordT expData;
		if (expRegIdx.size() == 0) begin
			$display("unexpected write-back to register %0d with data %h", gotReg, gotData);
			testErrors++;
		end else begin
			expIdx = expRegIdx.pop_front();
			expData = expRegData.pop_front();
			if (gotReg !== expIdx) begin
				$display("MISMATCH wbReg expected %h got %h", expIdx, gotReg);
				testErrors++;
			end
			if (gotData !== expData) begin
				$display("MISMATCH wbData expected %h got %h", expData, gotData);
				testErrors++;
			end
		end
	endtask

	task automatic checkStore(input pipePkg::dmemIdxT gotIdx, input isaPkg::wordT gotData);
		pipePkg::dmemIdxT expIdx;
		isaPkg::wordT expData;
		if (expStoreIdx.size() == 0) begin
			$display("unexpected store to word %0d with data %h", gotIdx, gotData);
			testErrors++;
		end else begin
			expIdx = expStoreIdx.pop_front();
			expData = expStoreData.pop_front();
			if (gotIdx !== expIdx) begin
				$display("MISMATCH storeAddr expected %h got %h", expIdx, gotIdx);
				testErrors++;
			end
			if (gotData !== expData) begin
				$display("MISMATCH storeData expected %h got %h", expData, gotData);
				testErrors++;
			end
		end
	endtask

	// sampled mid-cycle
	always @(negedge Reset) begin
		if (!clk && wbValid)
			checkReg(wbReg, wbData);
		if (!clk && storeValid)
			checkStore(storeAddr, storeData);
	end

	// ------------------------------------------------------------
	// load and run one program
	// ------------------------------------------------------------
	task automatic runTest(input string name);
		int cycles;
		@(posedge Reset);
		clk <= 1'b1;
		runModel();
		testErrors = 0;
		imemWrite <= 1'b1;
		for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
			imemAddr <= pipePkg::imemIdxT'(i);
			imemData <= prog[i];
			@(posedge Reset);
		end
		imemWrite <= 1'b0;
		repeat (3) @(posedge Reset);
		clk <= 1'b0;
		cycles = 0;
		while ((expRegIdx.size() != 0 || expStoreIdx.size() != 0) && cycles < 2000) begin
			@(posedge Reset);
			cycles++;
		end
		if (expRegIdx.size() != 0 || expStoreIdx.size() != 0) begin
			$display("%s: timed out with %0d write-backs and %0d stores still missing",
				name, expRegIdx.size(), expStoreIdx.size());
			testErrors++;
		end
		cycles = 0;
		while (cycles < 20) begin // catch late extra events
			@(posedge Reset);
			cycles++;
		end
		if (testErrors == 0) begin
			$display("%s: ok", name);
			passCount++;
		end else begin
			$display("%s: %0d errors", name, testErrors);
			failCount++;
		end
	endtask

	task automatic buildRandom();
		logic [31:0] r;
		isaPkg::immT imm;
		clearProgram();
		for (int n = 0; n < 40; n++) begin
			r = xorshift();
			imm = isaPkg::immT'(xorshift());
			case (r[10:9])
				2'd0: emit(encR(fnTable[r[13:11] % 5], r[2:0], r[5:3], r[8:6]));
				2'd1: emit(encI(`CPU_OP_ADDI, r[2:0], r[5:3], imm));
				2'd2: emit(encI(`CPU_OP_LW, r[2:0], r[5:3], imm));
				default: emit(encI(`CPU_OP_SW, r[2:0], r[5:3], imm));
			endcase
		end
		endProgram();
	endtask

	initial begin
		Reset = 1'b0;
		clk = 1'b1;
		imemWrite = 1'b0;
		imemAddr = '0;
		imemData = '0;
		passCount = 0;
		failCount = 0;

		clearProgram(); // back-to-back ALU chain
		emit(encI(`CPU_OP_ADDI, 1, 0, 16'd10));
		emit(encI(`CPU_OP_ADDI, 2, 1, 16'd3));
		emit(encR(`CPU_FN_ADD, 3, 1, 2));
		emit(encR(`CPU_FN_SUB, 4, 3, 1));
		emit(encR(`CPU_FN_AND, 5, 4, 3));
		emit(encR(`CPU_FN_OR, 6, 5, 1));
		emit(encR(`CPU_FN_SLT, 7, 1, 3));
		emit(encR(`CPU_FN_SLT, 8, 3, 1));
		emit(encR(`CPU_FN_SUB, 9, 1, 3)); // wraps
		emit(encR(`CPU_FN_SLT, 10, 1, 9)); // top bit set, unsigned compare
		endProgram();
		runTest("alu forwarding");

		clearProgram(); // stores, loads, load-use
		emit(encI(`CPU_OP_ADDI, 1, 0, 16'd8));
		emit(encI(`CPU_OP_ADDI, 2, 0, 16'd77));
		emit(encI(`CPU_OP_SW, 2, 1, 16'd0));
		emit(encI(`CPU_OP_LW, 3, 1, 16'd0));
		emit(encR(`CPU_FN_ADD, 4, 3, 3));
		emit(encI(`CPU_OP_LW, 5, 0, 16'd4));
		emit(encI(`CPU_OP_SW, 4, 1, 16'd12));
		emit(encI(`CPU_OP_LW, 6, 0, 16'd20));
		emit(encR(`CPU_FN_OR, 7, 6, 5));
		endProgram();
		runTest("load and store");

		clearProgram(); // branches
		emit(encI(`CPU_OP_ADDI, 1, 0, 16'd4));
		emit(encI(`CPU_OP_ADDI, 2, 0, 16'd4));
		emit(encI(`CPU_OP_BEQ, 2, 1, 16'd1));
		emit(encI(`CPU_OP_ADDI, 3, 0, 16'd99)); // skipped
		emit(encI(`CPU_OP_ADDI, 4, 0, 16'd1));
		emit(encI(`CPU_OP_BEQ, 1, 4, 16'd1));
		emit(encI(`CPU_OP_ADDI, 5, 0, 16'd2));
		emit(encI(`CPU_OP_ADDI, 7, 0, 16'd5));
		emit(encI(`CPU_OP_LW, 6, 0, 16'd0));
		emit(encI(`CPU_OP_BEQ, 7, 6, 16'd2));
		emit(encI(`CPU_OP_ADDI, 8, 0, 16'd11));
		emit(encI(`CPU_OP_ADDI, 9, 0, 16'd12));
		emit(encI(`CPU_OP_ADDI, 10, 6, 16'd3));
		emit(encI(`CPU_OP_BEQ, 0, 10, 16'd1));
		emit(encI(`CPU_OP_ADDI, 11, 0, 16'd1));
		endProgram();
		runTest("branches");

		clearProgram(); // jump over two words
		emit(encI(`CPU_OP_ADDI, 1, 0, 16'd1));
		emit(encJ(26'd4));
		emit(encI(`CPU_OP_ADDI, 2, 0, 16'd50));
		emit(encI(`CPU_OP_ADDI, 3, 0, 16'd60));
		emit(encI(`CPU_OP_ADDI, 4, 1, 16'd6));
		endProgram();
		runTest("jump");

		for (int t = 0; t < 3; t++) begin
			buildRandom();
			runTest($sformatf("random program %0d", t));
		end

		clearProgram(); // register 0 and reset values
		emit(encI(`CPU_OP_ADDI, 0, 0, 16'd55));
		emit(encR(`CPU_FN_ADD, 1, 0, 0));
		emit(encR(`CPU_FN_ADD, 2, 0, 9));
		emit(encI(`CPU_OP_ADDI, 0, 3, 16'd1));
		emit(encR(`CPU_FN_OR, 4, 0, 5));
		emit(encR(`CPU_FN_SUB, 6, 10, 11));
		emit(encR(`CPU_FN_SLT, 7, 0, 12));
		endProgram();
		runTest("register zero");

		$display("summary: %0d ok, %0d with errors", passCount, failCount);
		if (failCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/mipsCore.sv
// five-stage core; hold reset while loading the program, then watch the wb and store traces
`timescale 1ns/1ns
`default_nettype none

module mipsCore (
	input  wire                   Reset,
	input  wire                   clk,
	input  wire                   imemWrite,
	input  wire pipePkg::imemIdxT imemAddr,
	input  wire isaPkg::instrT    imemData,
	output logic                  wbValid,
	output isaPkg::regIdxT        wbReg,
	output isaPkg::wordT          wbData,
	output logic                  storeValid,
	output pipePkg::dmemIdxT      storeAddr,
	output isaPkg::wordT          storeData
);

	// fetch to decode
	isaPkg::instrT  fetchInstr;
	isaPkg::wordT   fetchPc;
	logic           fetchValid;
	logic           stall;
	logic           redirect;
	isaPkg::wordT   redirectPc;

	// decode to execute
	logic           idValid;
	isaPkg::regIdxT idRs;
	isaPkg::regIdxT idRt;
	isaPkg::regIdxT idRd;
	isaPkg::wordT   idData1;
	isaPkg::wordT   idData2;
	isaPkg::opcodeT idOpcode;
	isaPkg::functT  idFunct;
	isaPkg::immT    idImm;
	logic           idRegWrite;
	logic           idMemWrite;
	logic           idMemToReg;

	// execute to memory, partly fed back for hazards
	logic           exValid;
	isaPkg::wordT   exResult;
	isaPkg::wordT   exStoreData;
	isaPkg::regIdxT exDest;
	logic           exRegWrite;
	logic           exMemWrite;
	logic           exMemToReg;
	isaPkg::wordT   memResult;

	// port names match the nets one to one
	fetchUnit    u_fetchUnit    (.*);
	decodeStage  u_decodeStage  (.*);
	executeStage u_executeStage (.*);
	memoryStage  u_memoryStage  (.*);

endmodule

`default_nettype wire

//--- source/memoryStage.sv
// data memory indexed by the low 8 address bits, every word reset to 5
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module memoryStage (
	input  wire                 Reset,
	input  wire                 clk,
	input  wire                 exValid,
	input  wire isaPkg::wordT   exResult,
	input  wire isaPkg::wordT   exStoreData,
	input  wire isaPkg::regIdxT exDest,
	input  wire                 exRegWrite,
	input  wire                 exMemWrite,
	input  wire                 exMemToReg,
	output isaPkg::wordT        memResult,
	output logic                storeValid,
	output pipePkg::dmemIdxT    storeAddr,
	output isaPkg::wordT        storeData,
	output logic                wbValid,
	output isaPkg::regIdxT      wbReg,
	output isaPkg::wordT        wbData
);

	isaPkg::wordT     dmem [`CPU_DMEM_DEPTH];
	pipePkg::dmemIdxT dmemIdx;

	assign dmemIdx = pipePkg::dmemIdxT'(exResult);

	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
				dmem[i] <= `CPU_DMEM_RESET;
			end
		end else if (storeValid) begin
			dmem[dmemIdx] <= exStoreData; // lands at the end of the memory cycle
		end
	end

	assign memResult  = exMemToReg ? dmem[dmemIdx] : exResult;
	assign storeValid = exValid && exMemWrite;
	assign storeAddr  = dmemIdx;
	assign storeData  = exStoreData;

	// ------------------------------------------------------------
	// memory/write-back register
	// ------------------------------------------------------------
	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= exValid && exRegWrite; // register writes only
		end
	end

	always_ff @(posedge Reset) begin
		wbReg  <= exDest;
		wbData <= memResult;
	end

endmodule

`default_nettype wire

//--- source/executeStage.sv
// ALU treats immediates and slt as unsigned; memory stage wins over write-back when forwarding
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module executeStage (
	input  wire                 Reset,
	input  wire                 clk,
	input  wire                 idValid,
	input  wire isaPkg::regIdxT idRs,
	input  wire isaPkg::regIdxT idRt,
	input  wire isaPkg::regIdxT idRd,
	input  wire isaPkg::wordT   idData1,
	input  wire isaPkg::wordT   idData2,
	input  wire isaPkg::opcodeT idOpcode,
	input  wire isaPkg::functT  idFunct,
	input  wire isaPkg::immT    idImm,
	input  wire                 idRegWrite,
	input  wire                 idMemWrite,
	input  wire                 idMemToReg,
	input  wire isaPkg::wordT   memResult,
	input  wire                 wbValid,
	input  wire isaPkg::regIdxT wbReg,
	input  wire isaPkg::wordT   wbData,
	output logic                exValid,
	output isaPkg::wordT        exResult,
	output isaPkg::wordT        exStoreData,
	output isaPkg::regIdxT      exDest,
	output logic                exRegWrite,
	output logic                exMemWrite,
	output logic                exMemToReg
);

	// decode/execute register
	logic exeValid, exeRegWrite, exeMemWrite, exeMemToReg;
	isaPkg::regIdxT exeRs;
	isaPkg::regIdxT exeRt;
	isaPkg::regIdxT exeDest;
	isaPkg::wordT   exeData1;
	isaPkg::wordT   exeData2;
	isaPkg::opcodeT exeOpcode;
	isaPkg::functT  exeFunct;
	isaPkg::immT    exeImm;
	pipePkg::fwdSelT sel1;
	pipePkg::fwdSelT sel2;
	isaPkg::wordT   opA;
	isaPkg::wordT   opB;
	isaPkg::wordT   aluOut;

	function automatic pipePkg::fwdSelT fwdSel(isaPkg::regIdxT src);
		if (exRegWrite && exDest != '0 && exDest == src)
			return pipePkg::FWD_MEM;
		if (wbValid && wbReg != '0 && wbReg == src)
			return pipePkg::FWD_WB;
		return pipePkg::FWD_REG;
	endfunction

	function automatic isaPkg::wordT pick(pipePkg::fwdSelT sel, isaPkg::wordT regVal);
		case (sel)
			pipePkg::FWD_MEM: return memResult;
			pipePkg::FWD_WB:  return wbData;
			default:          return regVal;
		endcase
	endfunction

	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			exeValid    <= 1'b0;
			exeRegWrite <= 1'b0;
			exeMemWrite <= 1'b0;
			exeMemToReg <= 1'b0;
		end else begin
			exeValid    <= idValid;
			exeRegWrite <= idRegWrite;
			exeMemWrite <= idMemWrite;
			exeMemToReg <= idMemToReg;
		end
	end

	always_ff @(posedge Reset) begin
		exeRs     <= idRs;
		exeRt     <= idRt;
		exeDest   <= idRd;
		exeData1  <= idData1;
		exeData2  <= idData2;
		exeOpcode <= idOpcode;
		exeFunct  <= idFunct;
		exeImm    <= idImm;
	end

	// ------------------------------------------------------------
	// forwarding and ALU
	// ------------------------------------------------------------
	always_comb begin
		sel1 = fwdSel(exeRs);
		sel2 = fwdSel(exeRt);
		opA  = pick(sel1, exeData1);
		opB  = pick(sel2, exeData2); // also the store data
	end

	always_comb begin
		case (exeOpcode)
			`CPU_OP_RTYPE: begin
				case (exeFunct)
					`CPU_FN_ADD: aluOut = opA + opB;
					`CPU_FN_SUB: aluOut = opA - opB;
					`CPU_FN_AND: aluOut = opA & opB;
					`CPU_FN_OR:  aluOut = opA | opB;
					`CPU_FN_SLT: aluOut = isaPkg::wordT'(opA < opB);
					default:     aluOut = '0;
				endcase
			end
			`CPU_OP_ADDI, `CPU_OP_LW, `CPU_OP_SW: aluOut = opA + {16'b0, exeImm};
			default: aluOut = '0; // beq and j do nothing here
		endcase
	end

	// execute/memory register
	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			exValid    <= 1'b0;
			exRegWrite <= 1'b0;
			exMemWrite <= 1'b0;
			exMemToReg <= 1'b0;
		end else begin
			exValid    <= exeValid;
			exRegWrite <= exeRegWrite;
			exMemWrite <= exeMemWrite;
			exMemToReg <= exeMemToReg;
		end
	end

	always_ff @(posedge Reset) begin
		exResult    <= aluOut;
		exStoreData <= opB;
		exDest      <= exeDest;
	end

endmodule

`default_nettype wire

//--- source/fetchUnit.sv
// program is loaded through the write port while reset is held; pc wraps at 64 words
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module fetchUnit (
	input  wire                    Reset,
	input  wire                    clk,
	input  wire                    imemWrite,
	input  wire pipePkg::imemIdxT  imemAddr,
	input  wire isaPkg::instrT     imemData,
	input  wire                    stall,
	input  wire                    redirect,
	input  wire isaPkg::wordT      redirectPc,
	output isaPkg::instrT          fetchInstr,
	output isaPkg::wordT           fetchPc,
	output logic                   fetchValid
);

	isaPkg::instrT imem [`CPU_IMEM_DEPTH];
	isaPkg::wordT  pc;
	isaPkg::wordT  pcPlus4;
	isaPkg::instrT instr;

	assign pcPlus4 = pc + 32'd4;
	assign instr = imem[pipePkg::imemIdxT'(pc >> 2)]; // combinational read

	always_ff @(posedge Reset) begin
		if (imemWrite) begin
			imem[imemAddr] <= imemData;
		end
	end

	// ------------------------------------------------------------
	// pc and fetch/decode valid
	// ------------------------------------------------------------
	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			pc         <= '0;
			fetchValid <= 1'b0;
		end else if (redirect) begin
			pc         <= redirectPc;
			fetchValid <= 1'b0; // drop the word fetched behind the branch
		end else if (!stall) begin
			pc         <= pcPlus4;
			fetchValid <= 1'b1;
		end
	end

	always_ff @(posedge Reset) begin
		if (!stall && !redirect) begin
			fetchInstr <= instr;
			fetchPc    <= pcPlus4; // branch base
		end
	end

endmodule

`default_nettype wire

//--- decode/decodeStage.sv
// beq and j resolve here; a beq waits for sources still in execute or loaded in memory
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module decodeStage (
	input  wire                 Reset,
	input  wire                 clk,
	input  wire isaPkg::instrT  fetchInstr,
	input  wire isaPkg::wordT   fetchPc,
	input  wire                 fetchValid,
	input  wire isaPkg::regIdxT exDest,
	input  wire                 exRegWrite,
	input  wire                 exMemToReg,
	input  wire isaPkg::wordT   exResult,
	input  wire                 wbValid,
	input  wire isaPkg::regIdxT wbReg,
	input  wire isaPkg::wordT   wbData,
	output logic                stall,
	output logic                redirect,
	output isaPkg::wordT        redirectPc,
	output logic                idValid,
	output isaPkg::regIdxT      idRs,
	output isaPkg::regIdxT      idRt,
	output isaPkg::regIdxT      idRd,
	output isaPkg::wordT        idData1,
	output isaPkg::wordT        idData2,
	output isaPkg::opcodeT      idOpcode,
	output isaPkg::functT       idFunct,
	output isaPkg::immT         idImm,
	output logic                idRegWrite,
	output logic                idMemWrite,
	output logic                idMemToReg
);

	isaPkg::opcodeT  opcode;
	isaPkg::regIdxT  rs;
	isaPkg::regIdxT  rt;
	isaPkg::regIdxT  rd;
	isaPkg::immT     imm;
	isaPkg::jumpIdxT jumpIdx;
	logic isRtype, isJump, isBeq, isAddi, isLoad, isStore;
	isaPkg::wordT    rfData1;
	isaPkg::wordT    rfData2;
	isaPkg::wordT    cmpA;
	isaPkg::wordT    cmpB;
	logic loadUse, branchExe, branchLoad;
	// copy of the instruction now in execute
	logic            exeLoad;
	logic            exeWrites;
	isaPkg::regIdxT  exeDest;

	// register 0 never carries a hazard
	function automatic logic hits(isaPkg::regIdxT dest, isaPkg::regIdxT src);
		return dest != '0 && dest == src;
	endfunction

	assign opcode  = fetchInstr[31:26];
	assign rs      = fetchInstr[25:21];
	assign rt      = fetchInstr[20:16];
	assign rd      = fetchInstr[15:11];
	assign imm     = fetchInstr[15:0];
	assign jumpIdx = fetchInstr[25:0];

	assign isRtype = opcode == `CPU_OP_RTYPE;
	assign isJump  = opcode == `CPU_OP_J;
	assign isBeq   = opcode == `CPU_OP_BEQ;
	assign isAddi  = opcode == `CPU_OP_ADDI;
	assign isLoad  = opcode == `CPU_OP_LW;
	assign isStore = opcode == `CPU_OP_SW;

	// write-back reaches the reads through the bypass in the file
	registerFile u_registerFile (
		.Reset   (Reset),
		.clk     (clk),
		.rs      (rs),
		.rt      (rt),
		.wbValid (wbValid),
		.wbReg   (wbReg),
		.wbData  (wbData),
		.data1   (rfData1),
		.data2   (rfData2)
	);

	// ------------------------------------------------------------
	// hazards
	// ------------------------------------------------------------
	assign loadUse    = exeLoad && !isJump && (hits(exeDest, rs) || hits(exeDest, rt));
	assign branchExe  = isBeq && exeWrites && (hits(exeDest, rs) || hits(exeDest, rt));
	assign branchLoad = isBeq && exRegWrite && exMemToReg
		&& (hits(exDest, rs) || hits(exDest, rt)); // loaded data not ready yet
	assign stall      = fetchValid && (loadUse || branchExe || branchLoad);

	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			exeLoad   <= 1'b0;
			exeWrites <= 1'b0;
		end else begin
			exeLoad   <= idValid && isLoad;
			exeWrites <= idRegWrite;
		end
	end

	always_ff @(posedge Reset) begin
		exeDest <= idRd;
	end

	// ------------------------------------------------------------
	// branch compare and targets
	// ------------------------------------------------------------
	assign cmpA = (exRegWrite && hits(exDest, rs)) ? exResult : rfData1;
	assign cmpB = (exRegWrite && hits(exDest, rt)) ? exResult : rfData2;

	assign redirect   = fetchValid && !stall && (isJump || (isBeq && cmpA == cmpB));
	assign redirectPc = isJump ? {4'b0, jumpIdx, 2'b0} : fetchPc + {14'b0, imm, 2'b0};

	// to execute, a bubble while stalling
	assign idValid    = fetchValid && !stall;
	assign idRs       = rs;
	assign idRt       = rt;
	assign idRd       = isRtype ? rd : rt; // destination register
	assign idData1    = rfData1;
	assign idData2    = rfData2;
	assign idOpcode   = opcode;
	assign idFunct    = fetchInstr[5:0];
	assign idImm      = imm;
	assign idRegWrite = idValid && (isRtype || isAddi || isLoad);
	assign idMemWrite = idValid && isStore;
	assign idMemToReg = idValid && isLoad;

endmodule

`default_nettype wire

//--- decode/registerFile.sv
// register 0 reads zero and drops writes; others reset to 200
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module registerFile (
	input  wire                 Reset,
	input  wire                 clk,
	input  wire isaPkg::regIdxT rs,
	input  wire isaPkg::regIdxT rt,
	input  wire                 wbValid,
	input  wire isaPkg::regIdxT wbReg,
	input  wire isaPkg::wordT   wbData,
	output isaPkg::wordT        data1,
	output isaPkg::wordT        data2
);

	isaPkg::wordT regs [`CPU_NREGS];

	// zero register first, then the write of this cycle
	function automatic isaPkg::wordT readReg(isaPkg::regIdxT idx);
		if (idx == '0)
			return '0;
		if (wbValid && wbReg == idx)
			return wbData;
		return regs[idx];
	endfunction

	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= (i == 0) ? '0 : `CPU_REG_RESET;
			end
		end else if (wbValid && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	always_comb begin
		data1 = readReg(rs);
		data2 = readReg(rt);
	end

endmodule

`default_nettype wire

//--- common/pipePkg.sv
// pipeline-internal types; memory indices are word indices, not byte addresses
`default_nettype none

`include "cpu_macros.svh"

package pipePkg;

	typedef logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imemIdxT;
	typedef logic [$clog2(`CPU_DMEM_DEPTH)-1:0] dmemIdxT;

	// execute operand source
	typedef logic [1:0] fwdSelT;

	localparam fwdSelT FWD_REG = 2'd0; // value read in decode
	localparam fwdSelT FWD_MEM = 2'd1; // result of the memory stage
	localparam fwdSelT FWD_WB  = 2'd2; // write-back data

endpackage

`default_nettype wire

//--- common/isaPkg.sv
// instruction-set types for the MIPS-like subset; immediates are treated as unsigned
`default_nettype none

`include "cpu_macros.svh"

package isaPkg;

	// data and address word
	typedef logic [`CPU_XLEN-1:0] wordT;

	// raw instruction, always 32 bits regardless of data width
	typedef logic [31:0] instrT;

	typedef logic [$clog2(`CPU_NREGS)-1:0] regIdxT;

	// instruction fields
	typedef logic [5:0]  opcodeT;  // bits 31..26
	typedef logic [5:0]  functT;   // bits 5..0, R type only
	typedef logic [15:0] immT;     // immediate or branch offset in words
	typedef logic [25:0] jumpIdxT; // jump target in words

endpackage

`default_nettype wire

//--- common/cpu_macros.svh
// fixed architectural sizes and encodings of the core; only these values are supported
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ------------------------------------------------------------
// sizes
// ------------------------------------------------------------
`define CPU_XLEN        32
`define CPU_NREGS       32
`define CPU_IMEM_DEPTH  64
`define CPU_DMEM_DEPTH  256

`define CPU_REG_RESET   32'd200 // registers 1..31 after reset
`define CPU_DMEM_RESET  32'd5   // every data word after reset

// ------------------------------------------------------------
// opcodes and R-type funct codes
// ------------------------------------------------------------
`define CPU_OP_RTYPE    6'd0
`define CPU_OP_J        6'd2
`define CPU_OP_BEQ      6'd4
`define CPU_OP_ADDI     6'd8
`define CPU_OP_LW       6'd35
`define CPU_OP_SW       6'd43

`define CPU_FN_ADD      6'd32
`define CPU_FN_SUB      6'd34
`define CPU_FN_AND      6'd36
`define CPU_FN_OR       6'd37
`define CPU_FN_SLT      6'd42

`endif
